// ==== files.f ====
+incdir+tests
src/engine_prw_pkg.sv
src/prw_config_regs.sv
src/prw_packet_ingress.sv
src/prw_field_kernel.sv
src/prw_request_egress.sv
src/engine_prw_top.sv
tests/tb_engine_prw.sv

// ==== Bender.yml ====
package:
  name: engine_prw

sources:
  - files:
      - src/engine_prw_pkg.sv
      - src/prw_config_regs.sv
      - src/prw_packet_ingress.sv
      - src/prw_field_kernel.sv
      - src/prw_request_egress.sv
      - src/engine_prw_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_engine_prw.sv

// ==== tests/tb_prw_model.svh ====
// Reference model for the engine stage, included inside the testbench module
// Needs NF and the package widths visible where it is included

`ifndef TB_PRW_MODEL_SVH
`define TB_PRW_MODEL_SVH

// Expected results in arrival order, one entry per accepted packet
logic [NF*FIELD_W-1:0]         exp_fields_q [$];
logic [NF*2-1:0]               exp_states_q [$];
logic [FIELD_W-1:0]            exp_offset_q [$];
// Shift amount, direction, channel id, buffer id
logic [GRAN_W+1+2*ID_W-1:0]    exp_meta_q [$];

// Constant first, then the highest selected column, else an invalid zero field
function automatic void model_fields(
  input  logic [NF*FIELD_W-1:0] in_f,
  input  logic [NF*2-1:0]       in_s,
  input  logic [NF*NF-1:0]      ops,
  input  logic [NF-1:0]         cmask,
  input  logic [FIELD_W-1:0]    cval,
  output logic [NF*FIELD_W-1:0] out_f,
  output logic [NF*2-1:0]       out_s
);
  int src;
  out_f = '0;
  out_s = '0;
  for (int i = 0; i < NF; i++) begin
    src = -1;
    // Search from the top column down, first hit is the winner
    for (int j = NF - 1; j >= 0; j--) begin
      if (src < 0 && ops[i*NF + j]) begin
        src = j;
      end
    end
    if (cmask[i]) begin
      out_f[i*FIELD_W +: FIELD_W] = cval;
      out_s[i*2 +: 2]             = SEQUENCE_RUNNING;
    end else if (src >= 0) begin
      out_f[i*FIELD_W +: FIELD_W] = in_f[src*FIELD_W +: FIELD_W];
      out_s[i*2 +: 2]             = in_s[src*2 +: 2];
    end
  end
endfunction

// Offset from index start plus new field 1, wrapped then shifted
function automatic logic [FIELD_W-1:0] model_offset(
  input logic [FIELD_W-1:0] idx,
  input logic [FIELD_W-1:0] f1,
  input logic [GRAN_W-1:0]  gran,
  input logic               dir
);
  logic [FIELD_W-1:0] sum;
  sum = idx + f1;
  if (dir) begin
    return sum << gran;
  end else begin
    return sum >> gran;
  end
endfunction

// Model one accepted packet and queue its expected result
function automatic void push_expected(
  input logic [NF*FIELD_W-1:0] in_f,
  input logic [NF*2-1:0]       in_s,
  input logic [NF*NF-1:0]      ops,
  input logic [NF-1:0]         cmask,
  input logic [FIELD_W-1:0]    cval,
  input logic [FIELD_W-1:0]    idx,
  input logic [GRAN_W-1:0]     gran,
  input logic                  dir,
  input logic [ID_W-1:0]       chan,
  input logic [ID_W-1:0]       bufid
);
  logic [NF*FIELD_W-1:0] f;
  logic [NF*2-1:0]       s;
  model_fields(in_f, in_s, ops, cmask, cval, f, s);
  exp_fields_q.push_back(f);
  exp_states_q.push_back(s);
  exp_offset_q.push_back(model_offset(idx, f[FIELD_W +: FIELD_W], gran, dir));
  exp_meta_q.push_back({gran, dir, chan, bufid});
endfunction

`endif

// ==== tests/tb_engine_prw.sv ====
// Random-stimulus testbench for engine_prw_top at default parameters
// Config is rewritten only when no packet is in flight and all credits are back

`timescale 1ns/1ps

module tb_engine_prw import engine_prw_pkg::*; ();

  localparam int NF            = 4;
  localparam int IN_DEPTH      = 4;
  localparam int OUT_DEPTH     = 4;
  localparam int OUT_CREDITS   = 4;
  // Pass-through, constants, permutation, shifts, back-pressure
  localparam int TOTAL_PACKETS = 40 + 3*20 + 3*20 + 4*20 + 120;
  localparam int CYCLE_LIMIT   = 20 * TOTAL_PACKETS + 2000;

  logic                         ap_clk;
  logic                         rst_n;
  logic                         cfg_valid;
  logic [1:0]                   cfg_addr;
  cfg_word_u                    cfg_wdata;
  logic                         in_valid;
  logic [NF-1:0][FIELD_W-1:0]   in_fields;
  logic [NF-1:0][1:0]           in_states;
  logic                         in_credit;
  logic                         req_valid;
  logic [FIELD_W-1:0]           req_offset;
  logic [GRAN_W-1:0]            req_shift_amount;
  logic                         req_shift_dir;
  logic [ID_W-1:0]              req_id_channel;
  logic [ID_W-1:0]              req_id_buffer;
  logic [NF-1:0][FIELD_W-1:0]   res_fields;
  logic [NF-1:0][1:0]           res_states;
  logic                         out_credit;

  integer seed;
  integer credit_seed;
  int     errors;
  int     checked;
  int     accepted;
  int     in_credit_seen;
  int     up_credits;
  int     down_credits;
  int     cycle_count;
  logic   stall_mode;
  string  test_name;

  // Shadow of the programmed configuration
  logic [NF*NF-1:0]   cfg_ops;
  logic [NF-1:0]      cfg_cmask;
  logic [FIELD_W-1:0] cfg_cval;
  logic [FIELD_W-1:0] cfg_idx;
  logic [GRAN_W-1:0]  cfg_gran;
  logic               cfg_dir;
  logic [ID_W-1:0]    cfg_chan;
  logic [ID_W-1:0]    cfg_bufid;

  `include "tb_prw_model.svh"

  engine_prw_top #(
    .NUM_FIELDS (NF),
    .IN_DEPTH   (IN_DEPTH),
    .OUT_DEPTH  (OUT_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) engine_prw_top_i (
    .ap_clk          (ap_clk),
    .rst_n           (rst_n),
    .cfg_valid       (cfg_valid),
    .cfg_addr        (cfg_addr),
    .cfg_wdata       (cfg_wdata),
    .in_valid        (in_valid),
    .in_fields       (in_fields),
    .in_states       (in_states),
    .in_credit       (in_credit),
    .req_valid       (req_valid),
    .req_offset      (req_offset),
    .req_shift_amount(req_shift_amount),
    .req_shift_dir   (req_shift_dir),
    .req_id_channel  (req_id_channel),
    .req_id_buffer   (req_id_buffer),
    .res_fields      (res_fields),
    .res_states      (res_states),
    .out_credit      (out_credit)
  );

  always #4 ap_clk = ~ap_clk;

  // Run limit from the packet count
  always @(posedge ap_clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d packets checked",
               cycle_count, checked, accepted);
      $display("** FAIL **");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[ERROR] %s %s expected 0x%08h actual 0x%08h",
               test_name, label, expected, actual);
      errors++;
    end
  endtask

  // One falling edge, strobes drop and upstream credits come back
  task automatic next_cycle();
    @(negedge ap_clk);
    in_valid  = 1'b0;
    cfg_valid = 1'b0;
    if (in_credit) begin
      up_credits++;
      in_credit_seen++;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input cfg_word_u data);
    next_cycle();
    cfg_valid = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
  endtask

  // Engine is idle once every result is out and all credits are home
  task automatic drain();
    while (exp_offset_q.size() != 0 || down_credits != OUT_CREDITS ||
           up_credits < IN_DEPTH) begin
      next_cycle();
    end
  endtask

  task automatic start_test(input string name);
    drain();
    test_name = name;
  endtask

  task automatic apply_config(input logic [NF*NF-1:0] ops, input logic [NF-1:0] cmask,
                              input logic [GRAN_W-1:0] gran, input logic dir);
    cfg_word_u w;
    drain();
    cfg_ops   = ops;
    cfg_cmask = cmask;
    cfg_cval  = $random(seed);
    cfg_idx   = $random(seed);
    cfg_gran  = gran;
    cfg_dir   = dir;
    cfg_chan  = $random(seed);
    cfg_bufid = $random(seed);
    w = '0;
    for (int i = 0; i < NF; i++) begin
      for (int j = 0; j < NF; j++) begin
        w.ctrl.ops_mask[i][j] = ops[i*NF + j];
      end
    end
    w.ctrl.const_mask[NF-1:0] = cmask;
    w.ctrl.granularity        = gran;
    w.ctrl.direction          = dir;
    write_reg(CFG_ADDR_CTRL, w);
    w.raw = cfg_cval;
    write_reg(CFG_ADDR_CONST, w);
    w.raw = cfg_idx;
    write_reg(CFG_ADDR_INDEX, w);
    w.raw = {16'h0000, cfg_bufid, cfg_chan};
    write_reg(CFG_ADDR_IDS, w);
  endtask

  // Send while upstream holds a credit, rate is the percent chance per cycle
  task automatic send_packets(input int count, input int rate);
    logic [NF*FIELD_W-1:0] f;
    logic [NF*2-1:0]       s;
    int                    sent;
    sent = 0;
    while (sent < count) begin
      next_cycle();
      if (up_credits > 0 && ($unsigned($random(seed)) % 100) < rate) begin
        for (int i = 0; i < NF; i++) begin
          f[i*FIELD_W +: FIELD_W] = $random(seed);
          s[i*2 +: 2]             = $random(seed);
        end
        in_fields = f;
        in_states = s;
        in_valid  = 1'b1;
        up_credits--;
        accepted++;
        sent++;
        push_expected(f, s, cfg_ops, cfg_cmask, cfg_cval, cfg_idx,
                      cfg_gran, cfg_dir, cfg_chan, cfg_bufid);
      end
    end
  endtask

  function automatic logic [NF*NF-1:0] identity_ops();
    logic [NF*NF-1:0] ops;
    ops = '0;
    for (int i = 0; i < NF; i++) begin
      ops[i*NF + i] = 1'b1;
    end
    return ops;
  endfunction

  // Clears every row whose keep bit is low
  function automatic logic [NF*NF-1:0] zero_rows(input logic [NF*NF-1:0] ops,
                                                 input logic [NF-1:0] keep);
    for (int i = 0; i < NF; i++) begin
      if (!keep[i]) begin
        ops[i*NF +: NF] = '0;
      end
    end
    return ops;
  endfunction

  // ------------------------------
  // Response check and credit return
  // ------------------------------
  initial begin
    logic [NF*FIELD_W-1:0]      ef;
    logic [NF*2-1:0]            es;
    logic [FIELD_W-1:0]         eo;
    logic [GRAN_W+1+2*ID_W-1:0] em;
    int                         hold_left;
    hold_left    = 0;
    down_credits = OUT_CREDITS;
    out_credit   = 1'b0;
    forever begin
      @(negedge ap_clk);
      out_credit = 1'b0;
      if (rst_n) begin
        if (req_valid) begin
          if (down_credits == 0) begin
            $display("Request sent while the engine held no downstream credit");
            errors++;
          end else begin
            down_credits--;
          end
          if (exp_offset_q.size() == 0) begin
            $display("Request arrived with no expected result pending");
            errors++;
          end else begin
            ef = exp_fields_q.pop_front();
            es = exp_states_q.pop_front();
            eo = exp_offset_q.pop_front();
            em = exp_meta_q.pop_front();
            for (int i = 0; i < NF; i++) begin
              check_value($sformatf("field %0d", i), ef[i*FIELD_W +: FIELD_W], res_fields[i]);
              check_value($sformatf("state %0d", i), es[i*2 +: 2], res_states[i]);
            end
            check_value("offset", eo, req_offset);
            check_value("shift amount", em[2*ID_W+1 +: GRAN_W], req_shift_amount);
            check_value("shift dir", em[2*ID_W], req_shift_dir);
            check_value("channel id", em[ID_W +: ID_W], req_id_channel);
            check_value("buffer id", em[ID_W-1:0], req_id_buffer);
            checked++;
          end
        end
        // Long random holds while back-pressure is on
        if (stall_mode && hold_left == 0 && ($random(credit_seed) & 7) == 0) begin
          hold_left = 16 + ($unsigned($random(credit_seed)) % 48);
        end
        if (hold_left > 0) begin
          hold_left--;
        end else if (down_credits < OUT_CREDITS && ($random(credit_seed) & 3) != 0) begin
          out_credit = 1'b1;
          down_credits++;
        end
      end
    end
  end

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    logic [NF*NF-1:0] ops;
    seed        = 32'h6ba3fc54;
    credit_seed = $random(seed);
    ap_clk      = 1'b0;
    rst_n       = 1'b0;
    cfg_valid   = 1'b0;
    cfg_addr    = '0;
    cfg_wdata   = '0;
    in_valid    = 1'b0;
    in_fields   = '0;
    in_states   = '0;
    up_credits  = IN_DEPTH;
    stall_mode  = 1'b0;
    test_name   = "reset";
    repeat (5) @(posedge ap_clk);
    @(negedge ap_clk);
    rst_n = 1'b1;

    start_test("pass_through");
    apply_config(identity_ops(), '0, '0, 1'b0);
    send_packets(40, 60);

    start_test("const_invalid");
    repeat (3) begin
      ops = zero_rows($random(seed), $random(seed));
      apply_config(ops, $random(seed), '0, 1'b0);
      send_packets(20, 60);
    end

    // OR of two words leaves most rows with several bits set
    start_test("permutation");
    repeat (3) begin
      ops = $random(seed) | $random(seed);
      apply_config(ops, '0, '0, 1'b0);
      send_packets(20, 60);
    end

    start_test("offset_shift");
    repeat (4) begin
      ops = $random(seed);
      apply_config(ops, '0, $random(seed), $random(seed));
      send_packets(20, 60);
    end

    start_test("back_pressure");
    ops = $random(seed);
    apply_config(ops, $random(seed), $random(seed), $random(seed));
    stall_mode = 1'b1;
    send_packets(120, 100);
    stall_mode = 1'b0;
    drain();

    // Extra upstream credits push the seen count past the accepted count
    check_value("in_credit total", accepted, in_credit_seen);
    $display("Errors: %0d, packets accepted: %0d, packets checked: %0d",
             errors, accepted, checked);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : tb_engine_prw

// ==== src/engine_prw_top.sv ====
// Config writes are only safe while no packet is in flight
// Latency from in_valid to req_valid is at least 5 cycles and varies with credits

`timescale 1ns/1ps

module engine_prw_top import engine_prw_pkg::*; #(
  parameter int NUM_FIELDS  = 4,
  parameter int IN_DEPTH    = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                               ap_clk,
  input  logic                               rst_n,
  input  logic                               cfg_valid,
  input  logic [1:0]                         cfg_addr,
  input  cfg_word_u                          cfg_wdata,
  input  logic                               in_valid,
  input  logic [NUM_FIELDS-1:0][FIELD_W-1:0] in_fields,
  input  logic [NUM_FIELDS-1:0][1:0]         in_states,
  output logic                               in_credit,
  output logic                               req_valid,
  output logic [FIELD_W-1:0]                 req_offset,
  output logic [GRAN_W-1:0]                  req_shift_amount,
  output logic                               req_shift_dir,
  output logic [ID_W-1:0]                    req_id_channel,
  output logic [ID_W-1:0]                    req_id_buffer,
  output logic [NUM_FIELDS-1:0][FIELD_W-1:0] res_fields,
  output logic [NUM_FIELDS-1:0][1:0]         res_states,
  input  logic                               out_credit
);

  // Configuration
  logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] ops_mask;
  logic [NUM_FIELDS-1:0]                 const_mask;
  logic [FIELD_W-1:0]                    const_value;
  logic [FIELD_W-1:0]                    index_start;
  logic [GRAN_W-1:0]                     granularity;
  logic                                  direction;
  logic [ID_W-1:0]                       id_channel;
  logic [ID_W-1:0]                       id_buffer;
  // Ingress to kernel
  logic                                  issue_valid;
  logic [NUM_FIELDS-1:0][FIELD_W-1:0]    issue_fields;
  logic [NUM_FIELDS-1:0][1:0]            issue_states;
  // Kernel to egress, slot_free closes the credit loop
  logic                                  kout_valid;
  logic [NUM_FIELDS-1:0][FIELD_W-1:0]    kout_fields;
  logic [NUM_FIELDS-1:0][1:0]            kout_states;
  logic [FIELD_W-1:0]                    kout_offset;
  logic [GRAN_W-1:0]                     kout_shift_amount;
  logic                                  kout_shift_dir;
  logic [ID_W-1:0]                       kout_id_channel;
  logic [ID_W-1:0]                       kout_id_buffer;
  logic                                  slot_free;

  prw_config_regs #(
    .NUM_FIELDS(NUM_FIELDS)
  ) prw_config_regs_i (
    .ap_clk, .rst_n, .cfg_valid, .cfg_addr, .cfg_wdata,
    .ops_mask, .const_mask, .const_value, .index_start,
    .granularity, .direction, .id_channel, .id_buffer
  );

  prw_packet_ingress #(
    .NUM_FIELDS(NUM_FIELDS),
    .IN_DEPTH  (IN_DEPTH),
    .OUT_DEPTH (OUT_DEPTH)
  ) prw_packet_ingress_i (
    .ap_clk, .rst_n, .in_valid, .in_fields, .in_states, .slot_free,
    .in_credit, .issue_valid, .issue_fields, .issue_states
  );

  prw_field_kernel #(
    .NUM_FIELDS(NUM_FIELDS)
  ) prw_field_kernel_i (
    .ap_clk, .rst_n, .issue_valid, .issue_fields, .issue_states,
    .ops_mask, .const_mask, .const_value, .index_start,
    .granularity, .direction, .id_channel, .id_buffer,
    .kout_valid, .kout_fields, .kout_states, .kout_offset,
    .kout_shift_amount, .kout_shift_dir, .kout_id_channel, .kout_id_buffer
  );

  prw_request_egress #(
    .NUM_FIELDS (NUM_FIELDS),
    .OUT_DEPTH  (OUT_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) prw_request_egress_i (
    .ap_clk, .rst_n, .kout_valid, .kout_fields, .kout_states, .kout_offset,
    .kout_shift_amount, .kout_shift_dir, .kout_id_channel, .kout_id_buffer,
    .out_credit, .slot_free, .req_valid, .req_offset, .req_shift_amount,
    .req_shift_dir, .req_id_channel, .req_id_buffer, .res_fields, .res_states
  );

endmodule : engine_prw_top

// ==== src/prw_request_egress.sv ====
// Downstream may return at most OUT_CREDITS credits in total
// Sizing relies on ingress never issuing more than OUT_DEPTH packets ahead of slot_free

`timescale 1ns/1ps

module prw_request_egress import engine_prw_pkg::*; #(
  parameter int NUM_FIELDS  = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic                               ap_clk,
  input  logic                               rst_n,
  input  logic                               kout_valid,
  input  logic [NUM_FIELDS-1:0][FIELD_W-1:0] kout_fields,
  input  logic [NUM_FIELDS-1:0][1:0]         kout_states,
  input  logic [FIELD_W-1:0]                 kout_offset,
  input  logic [GRAN_W-1:0]                  kout_shift_amount,
  input  logic                               kout_shift_dir,
  input  logic [ID_W-1:0]                    kout_id_channel,
  input  logic [ID_W-1:0]                    kout_id_buffer,
  input  logic                               out_credit,
  output logic                               slot_free,
  output logic                               req_valid,
  output logic [FIELD_W-1:0]                 req_offset,
  output logic [GRAN_W-1:0]                  req_shift_amount,
  output logic                               req_shift_dir,
  output logic [ID_W-1:0]                    req_id_channel,
  output logic [ID_W-1:0]                    req_id_buffer,
  output logic [NUM_FIELDS-1:0][FIELD_W-1:0] res_fields,
  output logic [NUM_FIELDS-1:0][1:0]         res_states
);

  localparam int PTR_W  = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CNT_W  = $clog2(OUT_DEPTH + 1);
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);

  // One entry is a result packet plus its request descriptor
  logic [NUM_FIELDS-1:0][FIELD_W-1:0] fields_mem [OUT_DEPTH];
  logic [NUM_FIELDS-1:0][1:0]         states_mem [OUT_DEPTH];
  logic [FIELD_W-1:0]                 offset_mem [OUT_DEPTH];
  logic [GRAN_W-1:0]                  shift_mem  [OUT_DEPTH];
  logic                               dir_mem    [OUT_DEPTH];
  logic [ID_W-1:0]                    chan_mem   [OUT_DEPTH];
  logic [ID_W-1:0]                    buf_mem    [OUT_DEPTH];
  logic [PTR_W-1:0]                   wr_ptr;
  logic [PTR_W-1:0]                   rd_ptr;
  logic [CNT_W-1:0]                   count;
  logic [CRED_W-1:0]                  credits;
  logic                               send;

  // Each send spends one downstream credit
  assign send = (count != '0) && (credits != '0);

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      credits   <= CRED_W'(OUT_CREDITS);
      req_valid <= 1'b0;
      slot_free <= 1'b0;
    end else begin
      if (kout_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count     <= count + CNT_W'(kout_valid) - CNT_W'(send);
      credits   <= credits - CRED_W'(send) + CRED_W'(out_credit);
      req_valid <= send;
      // Slot goes back to ingress as a credit
      slot_free <= send;
    end
  end

  // Entry storage and output register
  always_ff @(posedge ap_clk) begin
    if (kout_valid) begin
      fields_mem[wr_ptr] <= kout_fields;
      states_mem[wr_ptr] <= kout_states;
      offset_mem[wr_ptr] <= kout_offset;
      shift_mem[wr_ptr]  <= kout_shift_amount;
      dir_mem[wr_ptr]    <= kout_shift_dir;
      chan_mem[wr_ptr]   <= kout_id_channel;
      buf_mem[wr_ptr]    <= kout_id_buffer;
    end
    if (send) begin
      res_fields       <= fields_mem[rd_ptr];
      res_states       <= states_mem[rd_ptr];
      req_offset       <= offset_mem[rd_ptr];
      req_shift_amount <= shift_mem[rd_ptr];
      req_shift_dir    <= dir_mem[rd_ptr];
      req_id_channel   <= chan_mem[rd_ptr];
      req_id_buffer    <= buf_mem[rd_ptr];
    end
  end

  // Ingress credit loop let the kernel overrun the FIFO
  a_no_write_full: assert property (
    @(posedge ap_clk) disable iff (!rst_n) kout_valid |-> (count < CNT_W'(OUT_DEPTH))
  );

  // Downstream returned more credits than it was given
  a_credit_bound: assert property (
    @(posedge ap_clk) disable iff (!rst_n) credits <= CRED_W'(OUT_CREDITS)
  );

endmodule : prw_request_egress

// ==== src/prw_field_kernel.sv ====
// Fixed 3-cycle pipeline with no stall, upstream credits bound it to OUT_DEPTH in flight
// NUM_FIELDS must be at least 2, field 1 feeds the offset

`timescale 1ns/1ps

module prw_field_kernel import engine_prw_pkg::*; #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                                  ap_clk,
  input  logic                                  rst_n,
  input  logic                                  issue_valid,
  input  logic [NUM_FIELDS-1:0][FIELD_W-1:0]    issue_fields,
  input  logic [NUM_FIELDS-1:0][1:0]            issue_states,
  input  logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] ops_mask,
  input  logic [NUM_FIELDS-1:0]                 const_mask,
  input  logic [FIELD_W-1:0]                    const_value,
  input  logic [FIELD_W-1:0]                    index_start,
  input  logic [GRAN_W-1:0]                     granularity,
  input  logic                                  direction,
  input  logic [ID_W-1:0]                       id_channel,
  input  logic [ID_W-1:0]                       id_buffer,
  output logic                                  kout_valid,
  output logic [NUM_FIELDS-1:0][FIELD_W-1:0]    kout_fields,
  output logic [NUM_FIELDS-1:0][1:0]            kout_states,
  output logic [FIELD_W-1:0]                    kout_offset,
  output logic [GRAN_W-1:0]                     kout_shift_amount,
  output logic                                  kout_shift_dir,
  output logic [ID_W-1:0]                       kout_id_channel,
  output logic [ID_W-1:0]                       kout_id_buffer
);

  logic [NUM_FIELDS-1:0][FIELD_W-1:0] sel_fields;
  logic [NUM_FIELDS-1:0][1:0]         sel_states;
  // Stage 1, selected packet plus its config copy
  logic                               s1_valid;
  logic [NUM_FIELDS-1:0][FIELD_W-1:0] s1_fields;
  logic [NUM_FIELDS-1:0][1:0]         s1_states;
  logic [FIELD_W-1:0]                 s1_index_start;
  logic [GRAN_W-1:0]                  s1_gran;
  logic                               s1_dir;
  logic [ID_W-1:0]                    s1_id_channel;
  logic [ID_W-1:0]                    s1_id_buffer;
  logic [FIELD_W-1:0]                 s1_sum;
  // Stage 2, offset ready
  logic                               s2_valid;
  logic [NUM_FIELDS-1:0][FIELD_W-1:0] s2_fields;
  logic [NUM_FIELDS-1:0][1:0]         s2_states;
  logic [FIELD_W-1:0]                 s2_offset;
  logic [GRAN_W-1:0]                  s2_gran;
  logic                               s2_dir;
  logic [ID_W-1:0]                    s2_id_channel;
  logic [ID_W-1:0]                    s2_id_buffer;

  // ------------------------------
  // Field selection
  // ------------------------------
  // Constant beats copy, copy beats invalid
  always_comb begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      sel_fields[i] = '0;
      sel_states[i] = SEQUENCE_INVALID;
      if (const_mask[i]) begin
        sel_fields[i] = const_value;
        sel_states[i] = SEQUENCE_RUNNING;
      end else begin
        // Ascending scan, so the highest set column wins
        for (int j = 0; j < NUM_FIELDS; j++) begin
          if (ops_mask[i][j]) begin
            sel_fields[i] = issue_fields[j];
            sel_states[i] = issue_states[j];
          end
        end
      end
    end
  end

  // Sum wraps at FIELD_W before the shift
  assign s1_sum = s1_index_start + s1_fields[1];

  // Valid chain
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid   <= 1'b0;
      s2_valid   <= 1'b0;
      kout_valid <= 1'b0;
    end else begin
      s1_valid   <= issue_valid;
      s2_valid   <= s1_valid;
      kout_valid <= s2_valid;
    end
  end

  // Payload stages, config rides alongside the packet
  always_ff @(posedge ap_clk) begin
    s1_fields         <= sel_fields;
    s1_states         <= sel_states;
    s1_index_start    <= index_start;
    s1_gran           <= granularity;
    s1_dir            <= direction;
    s1_id_channel     <= id_channel;
    s1_id_buffer      <= id_buffer;
    s2_fields         <= s1_fields;
    s2_states         <= s1_states;
    s2_offset         <= s1_dir ? (s1_sum << s1_gran) : (s1_sum >> s1_gran);
    s2_gran           <= s1_gran;
    s2_dir            <= s1_dir;
    s2_id_channel     <= s1_id_channel;
    s2_id_buffer      <= s1_id_buffer;
    kout_fields       <= s2_fields;
    kout_states       <= s2_states;
    kout_offset       <= s2_offset;
    kout_shift_amount <= s2_gran;
    kout_shift_dir    <= s2_dir;
    kout_id_channel   <= s2_id_channel;
    kout_id_buffer    <= s2_id_buffer;
  end

endmodule : prw_field_kernel

// ==== src/prw_packet_ingress.sv ====
// Upstream holds IN_DEPTH credits and pushes only with a credit in hand
// Issue is gated by OUT_DEPTH egress-slot credits, returned by slot_free

`timescale 1ns/1ps

module prw_packet_ingress import engine_prw_pkg::*; #(
  parameter int NUM_FIELDS = 4,
  parameter int IN_DEPTH   = 4,
  parameter int OUT_DEPTH  = 4
) (
  input  logic                                ap_clk,
  input  logic                                rst_n,
  input  logic                                in_valid,
  input  logic [NUM_FIELDS-1:0][FIELD_W-1:0]  in_fields,
  input  logic [NUM_FIELDS-1:0][1:0]          in_states,
  input  logic                                slot_free,
  output logic                                in_credit,
  output logic                                issue_valid,
  output logic [NUM_FIELDS-1:0][FIELD_W-1:0]  issue_fields,
  output logic [NUM_FIELDS-1:0][1:0]          issue_states
);

  localparam int PTR_W  = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W  = $clog2(IN_DEPTH + 1);
  localparam int CRED_W = $clog2(OUT_DEPTH + 1);

  logic [NUM_FIELDS-1:0][FIELD_W-1:0] fields_mem [IN_DEPTH];
  logic [NUM_FIELDS-1:0][1:0]         states_mem [IN_DEPTH];
  logic [PTR_W-1:0]                   wr_ptr;
  logic [PTR_W-1:0]                   rd_ptr;
  logic [CNT_W-1:0]                   count;
  logic [CRED_W-1:0]                  credits;
  logic                               pop;

  // Count is registered, so a packet pops one cycle after its push at the earliest
  assign pop = (count != '0) && (credits != '0);

  // ------------------------------
  // Pointers, occupancy, credits
  // ------------------------------
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      credits     <= CRED_W'(OUT_DEPTH);
      in_credit   <= 1'b0;
      issue_valid <= 1'b0;
    end else begin
      // Explicit wrap keeps non power-of-two depths working
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count       <= count + CNT_W'(in_valid) - CNT_W'(pop);
      credits     <= credits - CRED_W'(pop) + CRED_W'(slot_free);
      // One upstream credit per popped packet
      in_credit   <= pop;
      issue_valid <= pop;
    end
  end

  // Payload storage
  always_ff @(posedge ap_clk) begin
    if (in_valid) begin
      fields_mem[wr_ptr] <= in_fields;
      states_mem[wr_ptr] <= in_states;
    end
    if (pop) begin
      issue_fields <= fields_mem[rd_ptr];
      issue_states <= states_mem[rd_ptr];
    end
  end

  // Upstream pushed without holding a credit
  a_no_push_full: assert property (
    @(posedge ap_clk) disable iff (!rst_n) in_valid |-> (count < CNT_W'(IN_DEPTH))
  );

  // slot_free returned more than was taken
  a_credit_bound: assert property (
    @(posedge ap_clk) disable iff (!rst_n) credits <= CRED_W'(OUT_DEPTH)
  );

endmodule : prw_packet_ingress

// ==== src/prw_config_regs.sv ====
// Configuration bank, writes land on the next edge with no back-pressure
// Values are only meant to change while the engine is idle

`timescale 1ns/1ps

module prw_config_regs import engine_prw_pkg::*; #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                                  ap_clk,
  input  logic                                  rst_n,
  input  logic                                  cfg_valid,
  input  logic [1:0]                            cfg_addr,
  input  cfg_word_u                             cfg_wdata,
  output logic [NUM_FIELDS-1:0][NUM_FIELDS-1:0] ops_mask,
  output logic [NUM_FIELDS-1:0]                 const_mask,
  output logic [FIELD_W-1:0]                    const_value,
  output logic [FIELD_W-1:0]                    index_start,
  output logic [GRAN_W-1:0]                     granularity,
  output logic                                  direction,
  output logic [ID_W-1:0]                       id_channel,
  output logic [ID_W-1:0]                       id_buffer
);

  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      ops_mask    <= '0;
      const_mask  <= '0;
      const_value <= '0;
      index_start <= '0;
      granularity <= '0;
      direction   <= 1'b0;
      id_channel  <= '0;
      id_buffer   <= '0;
    end else if (cfg_valid) begin
      case (cfg_addr)
        CFG_ADDR_CTRL: begin
          // Only the rows and columns of live fields are kept
          for (int i = 0; i < NUM_FIELDS; i++) begin
            ops_mask[i] <= cfg_wdata.ctrl.ops_mask[i][NUM_FIELDS-1:0];
          end
          const_mask  <= cfg_wdata.ctrl.const_mask[NUM_FIELDS-1:0];
          granularity <= cfg_wdata.ctrl.granularity;
          direction   <= cfg_wdata.ctrl.direction;
        end
        CFG_ADDR_CONST: const_value <= cfg_wdata.raw;
        CFG_ADDR_INDEX: index_start <= cfg_wdata.raw;
        CFG_ADDR_IDS: begin
          id_channel <= cfg_wdata.raw[ID_W-1:0];
          id_buffer  <= cfg_wdata.raw[2*ID_W-1:ID_W];
        end
        default: ;
      endcase
    end
  end

  // An unknown address would silently drop or misroute a write
  a_cfg_addr_known: assert property (
    @(posedge ap_clk) disable iff (!rst_n) cfg_valid |-> !$isunknown(cfg_addr)
  );

endmodule : prw_config_regs

// ==== src/engine_prw_pkg.sv ====
// Shared widths, encodings and register map for the parallel read/write engine stage
// Control view supports at most MAX_FIELDS fields per packet

package engine_prw_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int FIELD_W    = 32;
  localparam int MAX_FIELDS = 4;
  localparam int GRAN_W     = 5;
  localparam int ID_W       = 8;

  // Per-field sequence state
  typedef enum logic [1:0] {
    SEQUENCE_INVALID = 2'd0,
    SEQUENCE_RUNNING = 2'd1,
    SEQUENCE_DONE    = 2'd2,
    SEQUENCE_STALL   = 2'd3
  } field_state_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam logic [1:0] CFG_ADDR_CTRL  = 2'd0;
  localparam logic [1:0] CFG_ADDR_CONST = 2'd1;
  localparam logic [1:0] CFG_ADDR_INDEX = 2'd2;
  // Low byte channel id, next byte buffer id
  localparam logic [1:0] CFG_ADDR_IDS   = 2'd3;

  // Control view, row i of ops_mask picks the source of output field i
  typedef struct packed {
    logic [MAX_FIELDS-1:0][MAX_FIELDS-1:0] ops_mask;
    logic [MAX_FIELDS-1:0]                 const_mask;
    logic [GRAN_W-1:0]                     granularity;
    // 1 shifts left
    logic                                  direction;
    logic [5:0]                            spare;
  } cfg_ctrl_t;

  // Write word, view depends on the register address
  typedef union packed {
    logic [31:0] raw;
    cfg_ctrl_t   ctrl;
  } cfg_word_u;

endpackage : engine_prw_pkg
